//--- game_cfg.svh
`ifndef GAME_CFG_SVH
`define GAME_CFG_SVH

// Points that end a match, must fit the three-bit score counters
`define WIN_SCORE 5

// Cycles between shots, also the delay to the first shot of a match
`define ROUND_LEN 32

// Nonzero start value of the striker's shift register
`define SHOT_SEED 8'h5a

`endif

//--- game_pkg.sv
`default_nettype none

package game_pkg;

// Phase of the match as seen by every block
typedef enum logic [1:0] {
    IDLE   = 2'b00,  // Waiting for a start strobe
    KEEPER = 2'b01,  // Rounds are being played
    OVER   = 2'b10   // Result shown until the next start
} g_state;

// Goal zone of a shot or a dive
typedef enum logic [1:0] {
    LEFT   = 2'b00,
    CENTER = 2'b01,
    RIGHT  = 2'b10
} zone_t;

endpackage

`default_nettype wire

//--- game_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module game_fsm import game_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   start,
    input  logic   match_end,
    output g_state game_state
);

g_state state_nxt;

always_ff @(posedge clk) begin
    if (rst) begin
        game_state <= IDLE;
    end else begin
        game_state <= state_nxt;
    end
end

always_comb begin
    state_nxt = game_state;  // Stay put unless an event arrives
    case (game_state)
        IDLE: begin
            if (start) begin
                state_nxt = KEEPER;
            end
        end
        KEEPER: begin
            // The score block ends the match, start has no effect here
            if (match_end) begin
                state_nxt = OVER;
            end
        end
        OVER: begin
            if (start) begin
                state_nxt = IDLE;  // A second start is needed to play again
            end
        end
        default: begin
            state_nxt = IDLE;
        end
    endcase
end

// The encoding has a fourth code that must never be reached
assert property (@(posedge clk) disable iff (rst)
    game_state inside {IDLE, KEEPER, OVER})
else $error("game_fsm: illegal state %b", game_state);

endmodule

`default_nettype wire

//--- shot_generator.sv
`timescale 1ns/1ps
`default_nettype none
`include "game_cfg.svh"

module shot_generator import game_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  g_state game_state,
    output logic   shot_valid,
    output zone_t  shot_zone
);

logic [7:0] lfsr;
logic [7:0] lfsr_nxt;
logic [$clog2(`ROUND_LEN)-1:0] round_cnt;
logic round_end;

// Galois form of x^8+x^6+x^5+x^4+1, shifting towards bit 0
assign lfsr_nxt = {1'b0, lfsr[7:1]} ^ (lfsr[0] ? 8'hb8 : 8'h00);

// Last cycle of a round, the shot is registered on the following edge
assign round_end = (game_state == KEEPER) && (32'(round_cnt) == `ROUND_LEN - 1);

always_ff @(posedge clk) begin
    if (rst) begin
        lfsr       <= `SHOT_SEED;
        round_cnt  <= '0;
        shot_valid <= 1'b0;
    end else begin
        lfsr       <= lfsr_nxt;  // Free running so the zone depends on timing too
        shot_valid <= round_end;
        if (game_state != KEEPER || round_end) begin
            round_cnt <= '0;
        end else begin
            round_cnt <= round_cnt + 1'b1;
        end
    end
end

// Zone is held from one shot to the next
always_ff @(posedge clk) begin
    if (round_end) begin
        case (lfsr[1:0])
            2'd0:    shot_zone <= LEFT;
            2'd2:    shot_zone <= RIGHT;
            default: shot_zone <= CENTER;  // Codes 1 and 3 both aim at the middle
        endcase
    end
end

// The striker only plays while the match is running
assert property (@(posedge clk) disable iff (rst)
    $rose(shot_valid) |-> game_state == KEEPER)
else $error("shot_generator: shot outside the keeper phase");

endmodule

`default_nettype wire

//--- keeper_control.sv
`timescale 1ns/1ps
`default_nettype none

module keeper_control import game_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  g_state game_state,
    input  logic   dive_valid,
    input  zone_t  dive_zone,
    input  logic   shot_valid,
    output logic   dive_held,
    output zone_t  held_zone
);

logic take_dive;

// A dive counts when nothing is held yet, or when the shot closes the old round
assign take_dive = (game_state == KEEPER) && dive_valid && (!dive_held || shot_valid);

always_ff @(posedge clk) begin
    if (rst) begin
        dive_held <= 1'b0;
    end else if (game_state != KEEPER) begin
        dive_held <= 1'b0;
    end else if (shot_valid) begin
        dive_held <= dive_valid;  // A dive with the shot opens the next round
    end else if (dive_valid) begin
        dive_held <= 1'b1;
    end
end

always_ff @(posedge clk) begin
    if (take_dive) begin
        held_zone <= dive_zone;  // Later dives in the round leave this alone
    end
end

endmodule

`default_nettype wire

//--- round_judge.sv
`timescale 1ns/1ps
`default_nettype none

module round_judge import game_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  shot_valid,
    input  zone_t shot_zone,
    input  logic  dive_held,
    input  zone_t held_zone,
    output logic  round_done,
    output logic  is_scored
);

logic saved;

// Only a held dive into the shot's zone stops the ball
assign saved = dive_held && (held_zone == shot_zone);

always_ff @(posedge clk) begin
    if (rst) begin
        round_done <= 1'b0;
        is_scored  <= 1'b0;
    end else begin
        round_done <= shot_valid;
        if (shot_valid) begin
            is_scored <= !saved;
        end else begin
            is_scored <= 1'b0;  // Low between results
        end
    end
end

// Each result follows its shot by exactly one cycle
assert property (@(posedge clk) disable iff (rst)
    round_done |-> $past(shot_valid))
else $error("round_judge: result without a shot in the previous cycle");

endmodule

`default_nettype wire

//--- score_control.sv
`timescale 1ns/1ps
`default_nettype none
`include "game_cfg.svh"

module score_control import game_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  g_state     game_state,
    input  logic       is_scored,
    input  logic       round_done,
    output logic       match_end,     // One-cycle pulse when a side has won
    output logic       match_result,  // Set for a player win and valid with match_end
    output logic [2:0] score_player,
    output logic [2:0] score_enemy
);

logic       match_end_nxt;
logic       match_result_nxt;
logic [2:0] score_player_nxt;
logic [2:0] score_enemy_nxt;
logic       player_won;
logic       enemy_won;

assign player_won = (score_player == 3'(`WIN_SCORE));
assign enemy_won  = (score_enemy == 3'(`WIN_SCORE));

always_ff @(posedge clk) begin
    if (rst) begin
        match_end    <= 1'b0;
        match_result <= 1'b0;
        score_player <= 3'd0;
        score_enemy  <= 3'd0;
    end else begin
        match_end    <= match_end_nxt;
        match_result <= match_result_nxt;
        score_player <= score_player_nxt;
        score_enemy  <= score_enemy_nxt;
    end
end

always_comb begin
    score_player_nxt = 3'd0;  // Everything clears outside the keeper phase
    score_enemy_nxt  = 3'd0;
    match_end_nxt    = 1'b0;
    match_result_nxt = 1'b0;
    if (game_state == KEEPER) begin
        score_player_nxt = score_player;
        score_enemy_nxt  = score_enemy;
        if (round_done && is_scored) begin
            score_enemy_nxt = score_enemy + 3'd1;
        end else if (round_done) begin
            score_player_nxt = score_player + 3'd1;  // A save is the player's point
        end
        // Scores stay at the final value until the FSM leaves KEEPER,
        // so the pulse is cut after its first cycle
        if (!match_end && (player_won || enemy_won)) begin
            match_end_nxt    = 1'b1;
            match_result_nxt = player_won;
        end
    end
end

// The FSM has left KEEPER long before another round can finish
assert property (@(posedge clk) disable iff (rst)
    score_player <= 3'(`WIN_SCORE) && score_enemy <= 3'(`WIN_SCORE))
else $error("score_control: score above the winning value");

endmodule

`default_nettype wire

//--- penalty_core.sv
`timescale 1ns/1ps
`default_nettype none

module penalty_core import game_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  logic       dive_valid,
    input  zone_t      dive_zone,
    output g_state     game_state,
    output logic       shot_valid,
    output zone_t      shot_zone,
    output logic       round_done,
    output logic       is_scored,
    output logic [2:0] score_player,
    output logic [2:0] score_enemy,
    output logic       match_end,
    output logic       match_result
);

logic  dive_held;
zone_t held_zone;

game_fsm game_fsm_inst (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .match_end  (match_end),
    .game_state (game_state)
);

shot_generator shot_generator_inst (
    .clk        (clk),
    .rst        (rst),
    .game_state (game_state),
    .shot_valid (shot_valid),
    .shot_zone  (shot_zone)
);

// The keeper and the striker run side by side during each round
keeper_control keeper_control_inst (
    .clk        (clk),
    .rst        (rst),
    .game_state (game_state),
    .dive_valid (dive_valid),
    .dive_zone  (dive_zone),
    .shot_valid (shot_valid),
    .dive_held  (dive_held),
    .held_zone  (held_zone)
);

round_judge round_judge_inst (
    .clk        (clk),
    .rst        (rst),
    .shot_valid (shot_valid),
    .shot_zone  (shot_zone),
    .dive_held  (dive_held),
    .held_zone  (held_zone),
    .round_done (round_done),
    .is_scored  (is_scored)
);

score_control score_control_inst (
    .clk          (clk),
    .rst          (rst),
    .game_state   (game_state),
    .is_scored    (is_scored),
    .round_done   (round_done),
    .match_end    (match_end),
    .match_result (match_result),
    .score_player (score_player),
    .score_enemy  (score_enemy)
);

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk
);

initial begin
    clk = 1'b0;
end

// Half period of 5 ns, so the first rising edge comes at 5 ns
always begin
    #5 clk = ~clk;
end

endmodule

`default_nettype wire

//--- penalty_core_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "game_cfg.svh"

module penalty_core_tb import game_pkg::*; ();

localparam int MATCHES        = 3;
localparam int TIMEOUT_CYCLES = MATCHES * 9 * `ROUND_LEN + 200;  // Longest matches plus margin

logic       clk;
logic       rst;
logic       start;
logic       dive_valid;
zone_t      dive_zone;
g_state     game_state;
logic       shot_valid;
zone_t      shot_zone;
logic       round_done;
logic       is_scored;
logic [2:0] score_player;
logic [2:0] score_enemy;
logic       match_end;
logic       match_result;

// Reference model of the match, one register per checked output
g_state     m_state;
int         m_age;        // Cycles since entering KEEPER or since the last shot
logic       m_shot;
logic       m_held;       // First dive of the current round has been seen
zone_t      m_hzone;
logic       m_done;
logic       m_scored;
logic [2:0] m_player;
logic [2:0] m_enemy;
logic       m_reached_d;
logic       m_end;
logic       m_result;
logic       reached;

int cycle_cnt;
int ends_seen;
int saves_seen;
int goals_seen;

tb_clock_gen clock_inst (
    .clk (clk)
);

penalty_core penalty_core_inst (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .dive_valid   (dive_valid),
    .dive_zone    (dive_zone),
    .game_state   (game_state),
    .shot_valid   (shot_valid),
    .shot_zone    (shot_zone),
    .round_done   (round_done),
    .is_scored    (is_scored),
    .score_player (score_player),
    .score_enemy  (score_enemy),
    .match_end    (match_end),
    .match_result (match_result)
);

task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("TESTS FAILED");
    $fatal(1);
endtask

task automatic report_mismatch(input string name, input int got, input int expected);
    fail_run($sformatf("mismatch at %0t: %s is %0d, expected %0d", $time, name, got, expected));
endtask

task automatic pulse_start();
    @(posedge clk);
    #1 start = 1'b1;
    @(posedge clk);
    #1 start = 1'b0;
endtask

// Plays one match from IDLE through OVER and back to IDLE
task automatic play_match();
    pulse_start();
    while (game_state == KEEPER) begin
        dive_valid = ($urandom_range(15, 0) == 0);  // About two dives per round
        dive_zone  = zone_t'($urandom_range(2, 0));
        @(posedge clk);
        #1;
    end
    dive_valid = 1'b0;
    repeat (2) @(posedge clk);
    #1 dive_valid = 1'b1;  // Dive while the match is over must be ignored
    @(posedge clk);
    #1 dive_valid = 1'b0;
    pulse_start();         // OVER back to IDLE
    repeat (3) @(posedge clk);
    #1;
endtask

assign reached = (m_player == 3'(`WIN_SCORE)) || (m_enemy == 3'(`WIN_SCORE));

always @(posedge clk) begin
    if (rst) begin
        m_state     <= IDLE;
        m_age       <= 0;
        m_shot      <= 1'b0;
        m_held      <= 1'b0;
        m_hzone     <= LEFT;
        m_done      <= 1'b0;
        m_scored    <= 1'b0;
        m_player    <= 3'd0;
        m_enemy     <= 3'd0;
        m_reached_d <= 1'b0;
        m_end       <= 1'b0;
        m_result    <= 1'b0;
    end else begin
        case (m_state)
            IDLE: begin
                if (start) begin
                    m_state <= KEEPER;
                end
            end
            KEEPER: begin
                if (m_end) begin
                    m_state <= OVER;
                end
            end
            OVER: begin
                if (start) begin
                    m_state <= IDLE;
                end
            end
            default: begin
                m_state <= IDLE;
            end
        endcase

        // One shot every ROUND_LEN cycles while the keeper phase lasts
        if (m_state == KEEPER && m_age == `ROUND_LEN - 1) begin
            m_shot <= 1'b1;
            m_age  <= 0;
        end else begin
            m_shot <= 1'b0;
            m_age  <= (m_state == KEEPER) ? m_age + 1 : 0;
        end

        // A dive in the shot cycle opens the next round
        if (m_state != KEEPER) begin
            m_held <= 1'b0;
        end else if (m_shot) begin
            m_held <= dive_valid;
            if (dive_valid) begin
                m_hzone <= dive_zone;
            end
        end else if (dive_valid && !m_held) begin
            m_held  <= 1'b1;
            m_hzone <= dive_zone;
        end

        m_done   <= m_shot;
        m_scored <= m_shot && !(m_held && m_hzone == shot_zone);

        if (m_state != KEEPER) begin
            m_player <= 3'd0;
            m_enemy  <= 3'd0;
        end else if (m_done && m_scored) begin
            m_enemy <= m_enemy + 3'd1;
        end else if (m_done) begin
            m_player <= m_player + 3'd1;
        end

        m_reached_d <= reached;
        m_end       <= (m_state == KEEPER) && reached && !m_reached_d;
        m_result    <= (m_state == KEEPER) && reached && !m_reached_d
                       && (m_player == 3'(`WIN_SCORE));
    end
end

always @(posedge clk) begin
    if (rst) begin
        cycle_cnt  <= 0;
        ends_seen  <= 0;
        saves_seen <= 0;
        goals_seen <= 0;
    end else begin
        cycle_cnt <= cycle_cnt + 1;
        if (match_end) begin
            ends_seen <= ends_seen + 1;
        end
        if (round_done && is_scored) begin
            goals_seen <= goals_seen + 1;
        end else if (round_done) begin
            saves_seen <= saves_seen + 1;
        end
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            fail_run($sformatf("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES));
        end
    end
end

// Outputs are compared on the falling edge where they sit half a cycle away from any change
assert property (@(negedge clk) disable iff (rst) game_state == m_state)
else report_mismatch("game_state", game_state, m_state);

assert property (@(negedge clk) disable iff (rst) shot_valid == m_shot)
else report_mismatch("shot_valid", shot_valid, m_shot);

assert property (@(negedge clk) disable iff (rst)
    shot_valid |-> shot_zone inside {LEFT, CENTER, RIGHT})
else fail_run($sformatf("shot_zone holds an illegal code at %0t", $time));

assert property (@(negedge clk) disable iff (rst) round_done == m_done)
else report_mismatch("round_done", round_done, m_done);

assert property (@(negedge clk) disable iff (rst) is_scored == m_scored)
else report_mismatch("is_scored", is_scored, m_scored);

assert property (@(negedge clk) disable iff (rst) score_player == m_player)
else report_mismatch("score_player", score_player, m_player);

assert property (@(negedge clk) disable iff (rst) score_enemy == m_enemy)
else report_mismatch("score_enemy", score_enemy, m_enemy);

assert property (@(negedge clk) disable iff (rst) match_end == m_end)
else report_mismatch("match_end", match_end, m_end);

assert property (@(negedge clk) disable iff (rst) match_result == m_result)
else report_mismatch("match_result", match_result, m_result);

initial begin : stimulus
    int m;
    void'($urandom(32'hadcb146e));
    rst        = 1'b1;
    start      = 1'b0;
    dive_valid = 1'b0;
    dive_zone  = LEFT;
    repeat (16) @(posedge clk);
    #1 rst = 1'b0;
    repeat (5) @(posedge clk);  // Quiet IDLE period before the first start
    #1;
    for (m = 0; m < MATCHES; m++) begin
        play_match();
    end
    $display("matches %0d, saves %0d, goals %0d", ends_seen, saves_seen, goals_seen);
    // Both kinds of round result have to occur for the score checks to mean anything
    if (ends_seen == MATCHES && saves_seen > 0 && goals_seen > 0) begin
        $display("TESTS PASSED");
        $finish;
    end else begin
        fail_run($sformatf("%0d of %0d matches ended with %0d saves and %0d goals",
                           ends_seen, MATCHES, saves_seen, goals_seen));
    end
end

endmodule

`default_nettype wire

//--- src.f
+incdir+.
game_pkg.sv
game_fsm.sv
shot_generator.sv
keeper_control.sv
round_judge.sv
score_control.sv
penalty_core.sv
tb_clock_gen.sv
penalty_core_tb.sv

//--- Makefile
# Verilator flow for the penalty shootout match logic

.PHONY: all lint clean

all: obj_dir/Vpenalty_core_tb
	@out=$$(./obj_dir/Vpenalty_core_tb); echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

obj_dir/Vpenalty_core_tb: src.f *.sv *.svh
	verilator --binary --timing --assert -f src.f --top-module penalty_core_tb

lint:
	verilator --lint-only -Wall --timing -f src.f --top-module penalty_core_tb

clean:
	rm -rf obj_dir
